// File: sim.f
cache_pkg.sv
cache_array.sv
line_merge.sv
cache_ctrl.sv
l1_cache.sv
l1_cache_chk.sv
tb_l1_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_l1_cache -f sim.f

sim_out="$(./obj_dir/Vtb_l1_cache || true)"
echo "$sim_out"

if grep -qF '*** TEST PASSED ***' <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: tb_l1_cache.sv
// ************************************************************************
// testbench for the L1 data cache with a three-busy-cycle memory model
// and a processor-view reference; it runs directed and random traffic
// and ends with a flush
// ************************************************************************

`timescale 1ns/1ps

module tb_l1_cache
    import cache_pkg::*;
();

    localparam int N_DIRECTED = 34;
    localparam int N_RANDOM   = 200;
    localparam int N_OPS      = N_DIRECTED + N_RANDOM + N_SETS + 1;   // readbacks and the flush
    localparam int MAX_CYCLES = N_OPS * 20 + N_SETS + 200;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     flush;
    logic     flush_done;

    word_t               mem_store [logic [31:0]];   // memory model contents
    word_t               cpu_view [logic [31:0]];    // what the processor wrote
    logic                m_valid [N_SETS];           // expected tag state
    logic                m_dirty [N_SETS];
    logic [TAG_BITS-1:0] m_tag [N_SETS];
    logic [31:0]         dirty_q [$];
    logic [31:0]         last_wb_addr;
    block_t              next_rdata;
    int                  errors;
    int                  mem_reads;
    int                  mem_writes;
    int                  wait_cnt;
    int                  cycles;
    integer              seed;

    l1_cache dut_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done)
    );

    always #4 CLK = ~CLK;

    function automatic word_t init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h5A3C_96E1;
    endfunction

    function automatic word_t mem_word(input logic [31:0] a);
        return mem_store.exists(a) ? mem_store[a] : init_word(a);
    endfunction

    // expected read data
    function automatic word_t ref_read(input logic [31:0] a);
        return cpu_view.exists(a) ? cpu_view[a] : init_word(a);
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // memory model samples the bus mid-cycle where every signal is settled
    always @(negedge CLK) begin
        if (nRST && (mem_req.ren || mem_req.wen)) begin
            if (!mem_rsp.busy) begin
                if (mem_req.wen) begin
                    check_eq("mem_req.wdata", mem_req.wdata,
                             {ref_read(mem_req.addr + 32'd4), ref_read(mem_req.addr)});
                    mem_store[mem_req.addr]         = mem_req.wdata[0];
                    mem_store[mem_req.addr + 32'd4] = mem_req.wdata[1];
                    last_wb_addr = mem_req.addr;
                    mem_writes++;
                end else begin
                    mem_reads++;
                end
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                next_rdata = {mem_word(mem_req.addr + 32'd4), mem_word(mem_req.addr)};
            end
        end else begin
            wait_cnt = 0;
        end
    end

    always @(posedge CLK) begin
        #1;
        mem_rsp.busy  = (wait_cnt < 3);    // low on the fourth cycle of a request
        mem_rsp.rdata = next_rdata;
    end

    // compares every completed read and records every completed write
    always @(negedge CLK) begin
        word_t w;
        if (nRST && !cpu_rsp.busy) begin
            if (cpu_req.ren) begin
                check_eq("cpu_rsp.rdata", 64'(cpu_rsp.rdata), 64'(ref_read(cpu_req.addr)));
            end else if (cpu_req.wen) begin
                w = ref_read(cpu_req.addr);
                for (int b = 0; b < 4; b++) begin
                    if (cpu_req.byte_en[b]) begin
                        w[b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
                    end
                end
                cpu_view[cpu_req.addr] = w;
            end
        end
    end

    initial begin
        do begin
            @(posedge CLK);
            cycles++;
        end while (cycles <= MAX_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // one processor access that starts 1 ns after a rising edge
    task automatic cpu_op(input logic is_write, input logic [31:0] addr, input word_t wdata,
                          input logic [3:0] be);
        cache_addr_t ca;
        cache_addr_t victim;
        logic        hit;
        logic        evict;
        int          r0;
        int          w0;
        ca             = cache_addr_t'(addr);
        hit            = m_valid[ca.set_idx] && (m_tag[ca.set_idx] == ca.tag);
        evict          = !hit && m_valid[ca.set_idx] && m_dirty[ca.set_idx];
        victim         = '0;
        victim.tag     = m_tag[ca.set_idx];
        victim.set_idx = ca.set_idx;
        r0             = mem_reads;
        w0             = mem_writes;
        cpu_req.ren     = !is_write;
        cpu_req.wen     = is_write;
        cpu_req.addr    = addr;
        cpu_req.wdata   = wdata;
        cpu_req.byte_en = be;
        do begin
            @(negedge CLK);
        end while (cpu_rsp.busy !== 1'b0);
        @(posedge CLK);
        #1;
        cpu_req.ren = 1'b0;
        cpu_req.wen = 1'b0;
        check_eq("memory read count", 64'(mem_reads - r0), hit ? 64'd0 : 64'd1);
        check_eq("memory write count", 64'(mem_writes - w0), evict ? 64'd1 : 64'd0);
        if (evict) begin
            check_eq("mem_req.addr", 64'(last_wb_addr), 64'(victim));
        end
        if (!hit) begin
            m_valid[ca.set_idx] = 1'b1;
            m_tag[ca.set_idx]   = ca.tag;
            m_dirty[ca.set_idx] = is_write;   // a write miss fills dirty
        end else if (is_write) begin
            m_dirty[ca.set_idx] = 1'b1;
        end
    endtask

    task automatic write_read(input logic [31:0] addr, input word_t wdata, input logic [3:0] be);
        cpu_op(1'b1, addr, wdata, be);
        cpu_op(1'b0, addr, '0, '0);
    endtask

    task automatic do_flush();
        int w0;
        int dirty_lines;
        dirty_lines = 0;
        for (int s = 0; s < N_SETS; s++) begin
            if (m_valid[s] && m_dirty[s]) begin
                dirty_lines++;
            end
        end
        w0    = mem_writes;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        do begin
            @(negedge CLK);
        end while (flush_done !== 1'b1);
        @(posedge CLK);
        #1;
        check_eq("flush write count", 64'(mem_writes - w0), 64'(dirty_lines));
        for (int s = 0; s < N_SETS; s++) begin
            m_valid[s] = 1'b0;
            m_dirty[s] = 1'b0;
        end
        foreach (cpu_view[a]) begin
            check_eq("memory word", 64'(mem_word(a)), 64'(cpu_view[a]));
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        CLK          = 1'b0;
        nRST         = 1'b0;
        cpu_req      = '0;
        mem_rsp      = '0;
        mem_rsp.busy = 1'b1;
        flush        = 1'b0;
        next_rdata   = '0;
        last_wb_addr = '0;
        errors       = 0;
        mem_reads    = 0;
        mem_writes   = 0;
        wait_cnt     = 0;
        cycles       = 0;
        seed         = 48;
        for (int s = 0; s < N_SETS; s++) begin
            m_valid[s] = 1'b0;
            m_dirty[s] = 1'b0;
            m_tag[s]   = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // untouched lines fill from memory and the other word then hits
        for (int i = 0; i < 8; i++) begin
            cpu_op(1'b0, 32'h0000_1000 + 32'(i * 8), '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            cpu_op(1'b0, 32'h0000_1004 + 32'(i * 8), '0, '0);
        end

        // byte, half and full word writes with the hits before the misses
        write_read(32'h0000_1000, 32'hDEAD_BEEF, 4'b0001);
        write_read(32'h0000_100C, 32'h1234_5678, 4'b1100);
        write_read(32'h0000_1010, 32'hCAFE_F00D, 4'b1111);
        write_read(32'h0000_1044, 32'hA5A5_0F0F, 4'b0010);
        write_read(32'h0000_1048, 32'h0BAD_CAFE, 4'b0011);
        write_read(32'h0000_1050, 32'h7654_3210, 4'b1111);

        // other tag in the dirty sets 0..2 pushes the victims out first
        for (int i = 0; i < 3; i++) begin
            cpu_op(1'b0, 32'h0000_3000 + 32'(i * 8), '0, '0);
            cpu_op(1'b0, 32'h0000_1000 + 32'(i * 8), '0, '0);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            a = 32'h0000_1000 + {22'd0, r[9:2], 2'b00};   // four tags over all sets
            cpu_op(r[10], a, $random(seed), (r[14:11] == 4'b0000) ? 4'b1111 : r[14:11]);
        end

        for (int s = 0; s < N_SETS; s++) begin
            if (m_valid[s] && m_dirty[s]) begin
                dirty_q.push_back({m_tag[s], SET_BITS'(s), 3'b000});
            end
        end
        do_flush();
        foreach (dirty_q[i]) begin
            cpu_op(1'b0, dirty_q[i], '0, '0);   // must miss after the flush
        end

        $display("errors: %0d, assertion failures: %0d, memory reads: %0d, memory writes: %0d",
                 errors, dut_i.ctrl_i.chk_i.assert_fails, mem_reads, mem_writes);
        if (errors == 0 && dut_i.ctrl_i.chk_i.assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: l1_cache_chk.sv
// ************************************************************************
// concurrent checks on the cache controller that are bound into cache_ctrl
// ************************************************************************

`timescale 1ns/1ps

module l1_cache_chk
    import cache_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input cpu_rsp_t cpu_rsp,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    input logic     flush_done,
    input logic     tag_wen,
    input logic     data_wen
);

    int clear_cycles;       // edges since reset up to N_SETS
    int assert_fails = 0;   // failed assertions so far

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            clear_cycles <= 0;
        end else if (clear_cycles < N_SETS) begin
            clear_cycles <= clear_cycles + 1;
        end
    end

    bus_one_way: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            assert_fails++;
            $error("memory read and write requested in the same cycle");
        end

    busy_in_clear: assert property (@(posedge CLK) disable iff (!nRST)
        (clear_cycles < N_SETS) |-> cpu_rsp.busy)
        else begin
            assert_fails++;
            $error("processor served during the clear sweep");
        end

    done_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            assert_fails++;
            $error("flush_done high for two cycles");
        end

    fill_writes_both: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren && !mem_rsp.busy) |-> (tag_wen && data_wen))
        else begin
            assert_fails++;
            $error("fill did not write tag and data together");
        end

endmodule

bind cache_ctrl l1_cache_chk chk_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .cpu_rsp    (cpu_rsp),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .flush_done (flush_done),
    .tag_wen    (tag_wen),
    .data_wen   (data_wen)
);

// File: l1_cache.sv
// ************************************************************************
// top level of the L1 data cache
// processor request/response on one side, block-wide memory on the other;
// flush is a one-cycle pulse answered by a one-cycle flush_done
// ************************************************************************

`timescale 1ns/1ps

module l1_cache
    import cache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    input  logic     flush,
    output logic     flush_done
);

    logic [SET_BITS-1:0] tag_sel;
    logic                tag_wen, data_wen;
    tag_entry_t          tag_wdata, tag_rdata;
    block_t              data_wdata, data_rdata;
    block_t              merge_src, merged;
    cache_addr_t         req_addr;

    assign req_addr = cache_addr_t'(cpu_req.addr);

    cache_ctrl ctrl_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done),
        .tag_sel    (tag_sel),
        .tag_wen    (tag_wen),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .data_wen   (data_wen),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .merge_src  (merge_src),
        .merged     (merged)
    );

    // both arrays follow the same index
    cache_array #(.entry_t(tag_entry_t)) tag_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (tag_sel),
        .wen   (tag_wen),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    cache_array #(.entry_t(block_t)) data_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (tag_sel),
        .wen   (data_wen),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    line_merge merge_i (
        .src      (merge_src),
        .word_sel (req_addr.word_idx),
        .wdata    (cpu_req.wdata),
        .byte_en  (cpu_req.byte_en),
        .merged   (merged)
    );

endmodule

// File: cache_ctrl.sv
// ************************************************************************
// controller of the direct-mapped write-back cache
// does hit detection, miss handling with victim write-back, the clear sweep
// after reset and the flush sweep, and drives both arrays and the memory bus
// ************************************************************************

`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  cpu_req_t            cpu_req,
    output cpu_rsp_t            cpu_rsp,
    output mem_req_t            mem_req,
    input  mem_rsp_t            mem_rsp,
    input  logic                flush,
    output logic                flush_done,
    output logic [SET_BITS-1:0] tag_sel,
    output logic                tag_wen,
    output tag_entry_t          tag_wdata,
    input  tag_entry_t          tag_rdata,
    output logic                data_wen,
    output block_t              data_wdata,
    input  block_t              data_rdata,
    output block_t              merge_src,
    input  block_t              merged
);

    cache_state_t state, next_state;
    logic [SET_BITS-1:0] set_cnt, next_set_cnt;   // shared by CLEAR and FLUSH
    logic sweep_done, next_sweep_done;
    logic flush_pend;
    logic flush_any;
    logic hit, victim_dirty, last_set, advance;
    cache_addr_t req_addr, fetch_addr, wb_addr;

    assign req_addr = cache_addr_t'(cpu_req.addr);

    // sweeps walk the counter, everything else indexes by the request
    assign tag_sel = (state == CLEAR || state == FLUSH) ? set_cnt : req_addr.set_idx;

    assign hit          = tag_rdata.valid && (tag_rdata.tag == req_addr.tag);
    assign victim_dirty = tag_rdata.valid && tag_rdata.dirty;
    assign last_set     = (set_cnt == SET_BITS'(N_SETS - 1));

    // block aligned bus addresses
    always_comb begin
        fetch_addr          = req_addr;
        fetch_addr.word_idx = '0;
        fetch_addr.byte_idx = '0;
        wb_addr.tag         = tag_rdata.tag;     // victim tag rebuilt with its set
        wb_addr.set_idx     = tag_sel;
        wb_addr.word_idx    = '0;
        wb_addr.byte_idx    = '0;
    end

    // a flush pulse seen outside LOOKUP waits here
    assign flush_any = flush || flush_pend;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= CLEAR;
            set_cnt    <= '0;
            sweep_done <= 1'b0;
            flush_pend <= 1'b0;
        end else begin
            state      <= next_state;
            set_cnt    <= next_set_cnt;
            sweep_done <= next_sweep_done;
            flush_pend <= flush_any && (state != LOOKUP);
        end
    end

    always_comb begin
        next_state      = state;
        next_set_cnt    = set_cnt;
        next_sweep_done = sweep_done;
        advance         = 1'b0;

        cpu_rsp.busy  = 1'b1;
        cpu_rsp.rdata = data_rdata[req_addr.word_idx];

        mem_req.ren   = 1'b0;
        mem_req.wen   = 1'b0;
        mem_req.addr  = fetch_addr;
        mem_req.wdata = data_rdata;     // only the victim is ever written out

        tag_wen    = 1'b0;
        tag_wdata  = '0;                 // invalid entry unless set below
        data_wen   = 1'b0;
        data_wdata = merged;
        merge_src  = data_rdata;
        flush_done = 1'b0;

        case (state)
            CLEAR: begin
                // one invalid tag per cycle
                tag_wen      = 1'b1;
                next_set_cnt = set_cnt + 1'b1;
                if (last_set) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (flush_any) begin
                    next_state = FLUSH;
                end else if (cpu_req.ren && hit) begin
                    cpu_rsp.busy = 1'b0;
                end else if (cpu_req.wen && hit) begin
                    cpu_rsp.busy    = 1'b0;
                    tag_wen         = 1'b1;
                    tag_wdata.valid = 1'b1;
                    tag_wdata.dirty = 1'b1;
                    tag_wdata.tag   = req_addr.tag;
                    data_wen        = 1'b1;
                end else if (cpu_req.ren || cpu_req.wen) begin
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                mem_req.wen  = 1'b1;
                mem_req.addr = wb_addr;
                if (!mem_rsp.busy) begin
                    next_state = FETCH;         // tag gets replaced by the fill
                end
            end
            FETCH: begin
                mem_req.ren = 1'b1;
                merge_src   = mem_rsp.rdata;    // write miss merges into the fill
                if (!mem_rsp.busy) begin
                    tag_wen         = 1'b1;
                    tag_wdata.valid = 1'b1;
                    tag_wdata.dirty = cpu_req.wen;
                    tag_wdata.tag   = req_addr.tag;
                    data_wen        = 1'b1;
                    data_wdata      = cpu_req.wen ? merged : mem_rsp.rdata;
                    next_state      = LOOKUP;
                end
            end
            FLUSH: begin
                if (sweep_done) begin
                    flush_done      = 1'b1;
                    next_sweep_done = 1'b0;
                    next_state      = LOOKUP;
                end else if (victim_dirty) begin
                    mem_req.wen  = 1'b1;
                    mem_req.addr = wb_addr;
                    advance      = !mem_rsp.busy;
                end else begin
                    advance = 1'b1;
                end
                // clear the line and move on once it is safe in memory
                if (advance) begin
                    tag_wen      = 1'b1;
                    next_set_cnt = set_cnt + 1'b1;
                    if (last_set) begin
                        next_sweep_done = 1'b1;
                    end
                end
            end
            default: begin
                next_state = CLEAR;
            end
        endcase
    end

endmodule

// File: line_merge.sv
// ************************************************************************
// folds one processor write word into a cache block
// only the byte lanes named by byte_en in the selected word change
// ************************************************************************

`timescale 1ns/1ps

module line_merge
    import cache_pkg::*;
(
    input  block_t                src,
    input  logic [WORD_BITS-1:0]  word_sel,
    input  word_t                 wdata,
    input  logic [BYTE_LANES-1:0] byte_en,
    output block_t                merged
);

    word_t lane_mask;   // ones on every bit of an enabled lane

    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            lane_mask[b*8 +: 8] = {8{byte_en[b]}};
        end
    end

    always_comb begin
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            if (WORD_BITS'(w) == word_sel) begin
                merged[w] = (src[w] & ~lane_mask) | (wdata & lane_mask);
            end else begin
                merged[w] = src[w];     // other words pass untouched
            end
        end
    end

endmodule

// File: cache_array.sv
// ************************************************************************
// set-indexed storage for the cache, one entry per set
// read is combinational on sel, write lands at the next edge when wen is high
// entry_t picks the payload (tag entries or data blocks)
// ************************************************************************

`timescale 1ns/1ps

module cache_array
    import cache_pkg::*;
#(
    parameter type entry_t = tag_entry_t
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [SET_BITS-1:0] sel,
    input  logic                wen,
    input  entry_t              wdata,
    output entry_t              rdata
);

    entry_t mem [N_SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[sel] <= wdata;
        end
    end

    // zero-latency lookup, controller compares tags in the same cycle
    assign rdata = mem[sel];

endmodule

// File: cache_pkg.sv
// ************************************************************************
// shared geometry, bus structs and FSM states of the L1 data cache
// import with cache_pkg::* in the module header of any file that needs it
// ************************************************************************

package cache_pkg;

    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = 32;                // 256 data bytes
    localparam int BYTE_LANES  = WORD_W / 8;
    localparam int BYTE_BITS   = $clog2(BYTE_LANES);
    localparam int SET_BITS    = $clog2(N_SETS);
    localparam int WORD_BITS   = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS    = ADDR_W - SET_BITS - WORD_BITS - BYTE_BITS;

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [BLOCK_WORDS-1:0] block_t;

    // address split, msb first
    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [SET_BITS-1:0]  set_idx;
        logic [WORD_BITS-1:0] word_idx;
        logic [BYTE_BITS-1:0] byte_idx;
    } cache_addr_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    // processor side
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        logic [ADDR_W-1:0]     addr;
        word_t                 wdata;
        logic [BYTE_LANES-1:0] byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // memory side, always one whole block per transfer
    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;    // block aligned
        block_t            wdata;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        CLEAR,
        LOOKUP,
        WRITEBACK,
        FETCH,
        FLUSH
    } cache_state_t;

endpackage
